// File: Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_l1_cache
FILELIST  = list.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: cache/cache_ctrl.sv
module cache_ctrl (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               req,
    input  cache_pkg::cpu_req_t                cpu_req,
    output logic                               busy,
    output logic                               resp_valid,
    output logic [cache_pkg::LINE_WIDTH-1:0]   rdata,
    output logic [cache_pkg::INDEX_BITS-1:0]   read_index,
    output logic [cache_pkg::TAG_BITS-1:0]     req_tag,
    output cache_pkg::way_write_t              way_wr [cache_pkg::NUM_WAYS],
    output logic                               clr,
    output logic [cache_pkg::INDEX_BITS-1:0]   clr_index,
    output logic                               lru,
    input  logic                               hit,
    input  logic [cache_pkg::WAY_BITS-1:0]     hit_way,
    input  logic [cache_pkg::LINE_WIDTH-1:0]   hit_data,
    input  logic [cache_pkg::WAY_BITS-1:0]     victim_way,
    input  cache_pkg::way_entry_t              victim_entry,
    output logic                               mem_rd,
    output logic                               mem_wr,
    output logic [cache_pkg::ADDR_WIDTH-1:0]   mem_addr,
    output logic [cache_pkg::LINE_WIDTH-1:0]   mem_wdata,
    input  logic                               mem_done,
    input  logic [cache_pkg::LINE_WIDTH-1:0]   mem_rdata
);

    cache_pkg::ctrl_state_t             state;
    cache_pkg::cpu_req_t                req_q;
    cache_pkg::way_entry_t              new_entry;
    logic [cache_pkg::WAY_BITS-1:0]     fill_way;
    logic [cache_pkg::LINE_WIDTH-1:0]   fill_data;
    logic                               sweeping;
    logic [cache_pkg::INDEX_BITS-1:0]   sweep_cnt;
    logic                               lru_bits [cache_pkg::NUM_SETS];

    assign read_index = req_q.addr[cache_pkg::OFFSET_BITS +: cache_pkg::INDEX_BITS];
    assign req_tag    = req_q.addr[cache_pkg::ADDR_WIDTH-1 -: cache_pkg::TAG_BITS];
    assign clr        = sweeping;
    assign clr_index  = sweep_cnt;
    assign lru        = lru_bits[read_index];

    // A write hit stores dirty data, a refill installs a clean line
    always_comb begin
        new_entry.valid = 1'b1;
        new_entry.tag   = req_tag;
        if (state == cache_pkg::ST_FILL) begin
            new_entry.dirty = 1'b0;
            new_entry.data  = fill_data;
        end else begin
            new_entry.dirty = 1'b1;
            new_entry.data  = req_q.wdata;
        end
    end

    always_comb begin
        for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
            way_wr[w].index = read_index;
            way_wr[w].entry = new_entry;
            way_wr[w].en    = 1'b0;
            if (state == cache_pkg::ST_LOOKUP && hit && req_q.op == cache_pkg::OP_WRITE &&
                hit_way == w[cache_pkg::WAY_BITS-1:0]) begin
                way_wr[w].en = 1'b1;
            end
            if (state == cache_pkg::ST_FILL && fill_way == w[cache_pkg::WAY_BITS-1:0]) begin
                way_wr[w].en = 1'b1;
            end
        end
    end

    // The accessed way makes the other one least recently used
    always_ff @(posedge clk) begin
        if (sweeping) begin
            lru_bits[sweep_cnt] <= 1'b0;
        end else if (state == cache_pkg::ST_LOOKUP && hit) begin
            lru_bits[read_index] <= ~hit_way;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= cache_pkg::ST_IDLE;
            busy       <= 1'b1;
            resp_valid <= 1'b0;
            mem_rd     <= 1'b0;
            mem_wr     <= 1'b0;
            sweeping   <= 1'b1;
            sweep_cnt  <= '0;
        end else begin
            resp_valid <= 1'b0;
            mem_rd     <= 1'b0;
            mem_wr     <= 1'b0;
            case (state)
                cache_pkg::ST_IDLE: begin
                    if (sweeping) begin
                        sweep_cnt <= sweep_cnt + 1'b1;
                        if (&sweep_cnt) begin
                            sweeping <= 1'b0;
                            busy     <= 1'b0;
                        end
                    end else if (req && !busy) begin
                        busy  <= 1'b1;
                        state <= cache_pkg::ST_LOOKUP;
                    end
                end
                cache_pkg::ST_LOOKUP: begin
                    if (hit) begin
                        resp_valid <= 1'b1;
                        busy       <= 1'b0;
                        state      <= cache_pkg::ST_IDLE;
                    end else if (victim_entry.valid && victim_entry.dirty) begin
                        state <= cache_pkg::ST_WRITEBACK;
                    end else begin
                        state <= cache_pkg::ST_REFILL;
                    end
                end
                cache_pkg::ST_WRITEBACK: begin
                    mem_wr <= 1'b1;
                    state  <= cache_pkg::ST_WB_WAIT;
                end
                cache_pkg::ST_WB_WAIT: begin
                    if (mem_done) begin
                        state <= cache_pkg::ST_REFILL;
                    end
                end
                cache_pkg::ST_REFILL: begin
                    mem_rd <= 1'b1;
                    state  <= cache_pkg::ST_REFILL_WAIT;
                end
                cache_pkg::ST_REFILL_WAIT: begin
                    if (mem_done) begin
                        state <= cache_pkg::ST_FILL;
                    end
                end
                cache_pkg::ST_FILL: begin
                    state <= cache_pkg::ST_LOOKUP;
                end
                default: begin
                    state <= cache_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // Request, miss bookkeeping and memory payload
    always_ff @(posedge clk) begin
        if (state == cache_pkg::ST_IDLE && req && !busy) begin
            req_q <= cpu_req;
        end
        if (state == cache_pkg::ST_LOOKUP) begin
            rdata    <= (req_q.op == cache_pkg::OP_WRITE) ? req_q.wdata : hit_data;
            fill_way <= victim_way;
        end
        if (state == cache_pkg::ST_WRITEBACK) begin
            mem_addr  <= {victim_entry.tag, read_index, {cache_pkg::OFFSET_BITS{1'b0}}};
            mem_wdata <= victim_entry.data;
        end
        if (state == cache_pkg::ST_REFILL) begin
            mem_addr <= {req_tag, read_index, {cache_pkg::OFFSET_BITS{1'b0}}};
        end
        if (state == cache_pkg::ST_REFILL_WAIT && mem_done) begin
            fill_data <= mem_rdata;
        end
    end

endmodule

// File: cache/cache_way.sv
module cache_way (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [cache_pkg::INDEX_BITS-1:0]   read_index,
    output cache_pkg::way_entry_t              rd_entry,
    input  cache_pkg::way_write_t              wr,
    input  logic [cache_pkg::INDEX_BITS-1:0]   clr_index,
    input  logic                               clr
);

    logic [cache_pkg::LINE_WIDTH-1:0] data_mem  [cache_pkg::NUM_SETS];
    logic [cache_pkg::TAG_BITS-1:0]   tag_mem   [cache_pkg::NUM_SETS];
    logic                             valid_mem [cache_pkg::NUM_SETS];
    logic                             dirty_mem [cache_pkg::NUM_SETS];

    // Asynchronous read of the addressed set
    always_comb begin
        rd_entry.valid = valid_mem[read_index];
        rd_entry.dirty = dirty_mem[read_index];
        rd_entry.tag   = tag_mem[read_index];
        rd_entry.data  = data_mem[read_index];
    end

    // Payload arrays only change on an explicit write
    always_ff @(posedge clk) begin
        if (wr.en) begin
            data_mem[wr.index] <= wr.entry.data;
            tag_mem[wr.index]  <= wr.entry.tag;
        end
    end

    // The status bits are swept clear one set per cycle after reset.
    // While rst is held the sweep index stays at set zero
    always_ff @(posedge clk) begin
        if (rst || clr) begin
            valid_mem[clr_index] <= 1'b0;
            dirty_mem[clr_index] <= 1'b0;
        end else if (wr.en) begin
            valid_mem[wr.index] <= wr.entry.valid;
            dirty_mem[wr.index] <= wr.entry.dirty;
        end
    end

endmodule

// File: cache/way_select.sv
module way_select (
    input  cache_pkg::way_entry_t              entries [cache_pkg::NUM_WAYS],
    input  logic [cache_pkg::TAG_BITS-1:0]     req_tag,
    input  logic                               lru,
    output logic                               hit,
    output logic [cache_pkg::WAY_BITS-1:0]     hit_way,
    output logic [cache_pkg::LINE_WIDTH-1:0]   hit_data,
    output logic [cache_pkg::WAY_BITS-1:0]     victim_way,
    output cache_pkg::way_entry_t              victim_entry
);

    logic                               any_invalid;
    logic [cache_pkg::WAY_BITS-1:0]     invalid_way;

    // Tag compare across all ways; at most one way can match
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = cache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
            if (entries[w].valid && entries[w].tag == req_tag) begin
                hit     = 1'b1;
                hit_way = w[cache_pkg::WAY_BITS-1:0];
            end
        end
    end

    assign hit_data = entries[hit_way].data;

    // Lowest numbered free way wins, scanning from the top down
    always_comb begin
        any_invalid = 1'b0;
        invalid_way = '0;
        for (int w = cache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
            if (!entries[w].valid) begin
                any_invalid = 1'b1;
                invalid_way = w[cache_pkg::WAY_BITS-1:0];
            end
        end
    end

    // With both ways full the LRU bit names the way to replace
    assign victim_way   = any_invalid ? invalid_way : lru;
    assign victim_entry = entries[victim_way];

endmodule

// File: common/cache_pkg.sv
package cache_pkg;

    // Cache geometry
    localparam int NUM_WAYS    = 2;
    localparam int NUM_SETS    = 512;
    localparam int INDEX_BITS  = 9;
    localparam int OFFSET_BITS = 2;
    localparam int TAG_BITS    = 21;
    localparam int LINE_WIDTH  = 32;
    localparam int ADDR_WIDTH  = 32;
    localparam int WAY_BITS    = $clog2(NUM_WAYS);

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } cpu_op_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_WB_WAIT,
        ST_REFILL,
        ST_REFILL_WAIT,
        ST_FILL
    } ctrl_state_t;

    // Request as sampled from the processor side
    typedef struct packed {
        cpu_op_t                op;
        logic [ADDR_WIDTH-1:0]  addr;
        logic [LINE_WIDTH-1:0]  wdata;
    } cpu_req_t;

    // One line of one way
    typedef struct packed {
        logic                   valid;
        logic                   dirty;
        logic [TAG_BITS-1:0]    tag;
        logic [LINE_WIDTH-1:0]  data;
    } way_entry_t;

    typedef struct packed {
        logic                   en;
        logic [INDEX_BITS-1:0]  index;
        way_entry_t             entry;
    } way_write_t;

endpackage

// File: hdl/l1_cache_top.sv
module l1_cache_top (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               req,
    input  cache_pkg::cpu_req_t                cpu_req,
    output logic                               busy,
    output logic                               resp_valid,
    output logic [cache_pkg::LINE_WIDTH-1:0]   rdata,
    output logic                               mem_rd,
    output logic                               mem_wr,
    output logic [cache_pkg::ADDR_WIDTH-1:0]   mem_addr,
    output logic [cache_pkg::LINE_WIDTH-1:0]   mem_wdata,
    input  logic                               mem_done,
    input  logic [cache_pkg::LINE_WIDTH-1:0]   mem_rdata
);

    logic [cache_pkg::INDEX_BITS-1:0]   read_index;
    logic [cache_pkg::TAG_BITS-1:0]     req_tag;
    logic [cache_pkg::INDEX_BITS-1:0]   clr_index;
    logic                               clr;
    logic                               lru;
    logic                               hit;
    logic [cache_pkg::WAY_BITS-1:0]     hit_way;
    logic [cache_pkg::LINE_WIDTH-1:0]   hit_data;
    logic [cache_pkg::WAY_BITS-1:0]     victim_way;
    cache_pkg::way_entry_t              victim_entry;
    cache_pkg::way_entry_t              entries [cache_pkg::NUM_WAYS];
    cache_pkg::way_write_t              way_wr  [cache_pkg::NUM_WAYS];

    cache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .cpu_req      (cpu_req),
        .busy         (busy),
        .resp_valid   (resp_valid),
        .rdata        (rdata),
        .read_index   (read_index),
        .req_tag      (req_tag),
        .way_wr       (way_wr),
        .clr          (clr),
        .clr_index    (clr_index),
        .lru          (lru),
        .hit          (hit),
        .hit_way      (hit_way),
        .hit_data     (hit_data),
        .victim_way   (victim_way),
        .victim_entry (victim_entry),
        .mem_rd       (mem_rd),
        .mem_wr       (mem_wr),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_done     (mem_done),
        .mem_rdata    (mem_rdata)
    );

    // One storage array per way, all sharing the read index and the sweep
    for (genvar w = 0; w < cache_pkg::NUM_WAYS; w++) begin : g_way
        cache_way u_way (
            .clk        (clk),
            .rst        (rst),
            .read_index (read_index),
            .rd_entry   (entries[w]),
            .wr         (way_wr[w]),
            .clr_index  (clr_index),
            .clr        (clr)
        );
    end

    way_select u_sel (
        .entries      (entries),
        .req_tag      (req_tag),
        .lru          (lru),
        .hit          (hit),
        .hit_way      (hit_way),
        .hit_data     (hit_data),
        .victim_way   (victim_way),
        .victim_entry (victim_entry)
    );

endmodule

// File: list.f
common/cache_pkg.sv
cache/cache_way.sv
cache/way_select.sv
cache/cache_ctrl.sv
hdl/l1_cache_top.sv
tests/cache_assert.sv
tests/cache_checker.sv
tests/tb_l1_cache.sv

// File: tests/cache_assert.sv
module cache_assert (
    input logic clk,
    input logic rst,
    input logic req,
    input logic busy,
    input logic resp_valid,
    input logic mem_rd,
    input logic mem_wr,
    input logic hit
);

    timeunit 1ns;
    timeprecision 1ps;

    int err_req    = 0;
    int err_strobe = 0;
    int err_pulse  = 0;
    int err_hit    = 0;
    int err_total;

    assign err_total = err_req + err_strobe + err_pulse + err_hit;

    // The processor may only request while the cache is idle
    req_while_idle: assert property (@(posedge clk) disable iff (rst) busy |-> !req)
        else begin
            err_req++;
            $error("req asserted while busy");
        end

    one_strobe: assert property (@(posedge clk) disable iff (rst) !(mem_rd && mem_wr))
        else begin
            err_strobe++;
            $error("mem_rd and mem_wr high together");
        end

    resp_pulse: assert property (@(posedge clk) disable iff (rst) resp_valid |=> !resp_valid)
        else begin
            err_pulse++;
            $error("resp_valid longer than one cycle");
        end

    // A lookup that hits on the first try answers on the next edge
    hit_latency: assert property (@(posedge clk) disable iff (rst)
                                  ($past(req && !busy) && hit) |=> resp_valid)
        else begin
            err_hit++;
            $error("hit did not respond two cycles after req");
        end

endmodule

bind l1_cache_top cache_assert u_assert (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .busy       (busy),
    .resp_valid (resp_valid),
    .mem_rd     (mem_rd),
    .mem_wr     (mem_wr),
    .hit        (hit)
);

// File: tests/cache_checker.sv
module cache_checker (
    input  logic        clk,
    input  logic        rst,
    input  logic        req,
    input  logic        busy,
    input  logic        resp_valid,
    input  logic [31:0] rdata,
    input  logic        mem_rd,
    input  logic        mem_wr,
    input  int          row_idx,
    input  logic [31:0] exp_rdata,
    input  int          exp_rd,
    input  int          exp_wr,
    output int          pass_cnt,
    output int          fail_cnt
);

    timeunit 1ns;
    timeprecision 1ps;

    int   rd_seen      = 0;
    int   wr_seen      = 0;
    int   idle_seen    = 0;
    int   passes       = 0;
    int   fails        = 0;
    logic idle_checked = 1'b0;

    assign pass_cnt = passes;
    assign fail_cnt = fails;

    function automatic int compare_value(input string label, input string name,
                                         input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s signal %s expected %0h, got %0h",
                     $time, label, name, expected, actual);
            return 1;
        end
        return 0;
    endfunction

    task automatic tally(input int errs, input string label);
        if (errs == 0) begin
            $display("%s passed", label);
            passes <= passes + 1;
        end else begin
            fails <= fails + 1;
        end
    endtask

    // Once the reset sweep ends the cache must be quiet
    task automatic check_idle();
        int errs;
        errs = compare_value("post reset", "resp_valid", 32'd0, {31'd0, resp_valid});
        errs += compare_value("post reset", "mem_rd", 32'd0, {31'd0, mem_rd});
        errs += compare_value("post reset", "mem_wr", 32'd0, {31'd0, mem_wr});
        tally(errs, "post reset idle check");
    endtask

    // Busy must stay high from the accepted request until it drops with resp_valid
    task automatic check_row();
        string label;
        int    errs;
        label = $sformatf("row %0d", row_idx);
        errs  = compare_value(label, "rdata", exp_rdata, rdata);
        errs += compare_value(label, "mem_rd count", exp_rd, rd_seen);
        errs += compare_value(label, "mem_wr count", exp_wr, wr_seen);
        errs += compare_value(label, "busy", 32'd0, {31'd0, busy});
        errs += compare_value(label, "busy low cycles", 32'd0, idle_seen);
        tally(errs, $sformatf("%s (rdata %h, mem_rd %0d, mem_wr %0d)",
                              label, rdata, rd_seen, wr_seen));
    endtask

    always @(posedge clk) begin
        if (rst) begin
            idle_checked <= 1'b0;
        end else if (!idle_checked && busy === 1'b0) begin
            idle_checked <= 1'b1;
            check_idle();
        end else if (req && !busy) begin
            rd_seen   <= 0;
            wr_seen   <= 0;
            idle_seen <= 0;
        end else if (resp_valid) begin
            check_row();
        end else begin
            if (mem_rd) begin
                rd_seen <= rd_seen + 1;
            end
            if (mem_wr) begin
                wr_seen <= wr_seen + 1;
            end
            if (busy !== 1'b1) begin
                idle_seen <= idle_seen + 1;
            end
        end
    end

endmodule

// File: tests/tb_l1_cache.sv
module tb_l1_cache;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ROWS      = 19;
    localparam int READY_TIMEOUT = 2000;
    localparam int RESP_TIMEOUT  = 200;

    // Set 5 is shared by four tags, the other sets see only cold traffic
    localparam logic [31:0] S5_T1   = 32'h0000_0814;
    localparam logic [31:0] S5_T2   = 32'h0000_1014;
    localparam logic [31:0] S5_T3   = 32'h0000_1814;
    localparam logic [31:0] S5_T4   = 32'h0000_2014;
    localparam logic [31:0] S511_T7 = 32'h0000_3FFC;
    localparam logic [31:0] S0_T0   = 32'h0000_0000;
    localparam logic [31:0] S0_TMAX = 32'hFFFF_F800;
    localparam logic [31:0] S1_T0   = 32'h0000_0004;

    localparam cache_pkg::cpu_op_t RD = cache_pkg::OP_READ;
    localparam cache_pkg::cpu_op_t WR = cache_pkg::OP_WRITE;

    typedef struct packed {
        cache_pkg::cpu_op_t op;
        logic [31:0]        addr;
        logic [31:0]        wdata;
        logic [31:0]        exp_rdata;
        int                 exp_rd;
        int                 exp_wr;
    } row_t;

    logic                clk       = 1'b0;
    logic                rst       = 1'b1;
    logic                req       = 1'b0;
    cache_pkg::cpu_req_t cpu_req   = '0;
    logic                mem_done  = 1'b0;
    logic [31:0]         mem_rdata = '0;
    logic                busy;
    logic                resp_valid;
    logic [31:0]         rdata;
    logic                mem_rd;
    logic                mem_wr;
    logic [31:0]         mem_addr;
    logic [31:0]         mem_wdata;

    int                  row_idx   = 0;
    logic [31:0]         exp_rdata = '0;
    int                  exp_rd    = 0;
    int                  exp_wr    = 0;
    int                  pass_cnt;
    int                  fail_cnt;
    logic                run_ok;
    row_t                rows [NUM_ROWS];

    logic [31:0]         mem [logic [31:0]];
    logic [31:0]         lcg_state    = 32'd41;
    logic                mem_pending  = 1'b0;
    logic                mem_is_rd    = 1'b0;
    logic [31:0]         mem_req_addr = '0;
    int                  mem_wait     = 0;

    l1_cache_top u_l1_cache_top (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .cpu_req    (cpu_req),
        .busy       (busy),
        .resp_valid (resp_valid),
        .rdata      (rdata),
        .mem_rd     (mem_rd),
        .mem_wr     (mem_wr),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_done   (mem_done),
        .mem_rdata  (mem_rdata)
    );

    cache_checker u_checker (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .busy       (busy),
        .resp_valid (resp_valid),
        .rdata      (rdata),
        .mem_rd     (mem_rd),
        .mem_wr     (mem_wr),
        .row_idx    (row_idx),
        .exp_rdata  (exp_rdata),
        .exp_rd     (exp_rd),
        .exp_wr     (exp_wr),
        .pass_cnt   (pass_cnt),
        .fail_cnt   (fail_cnt)
    );

    // Memory never written returns a value derived from its address
    function automatic logic [31:0] fresh_value(input logic [31:0] addr);
        return addr ^ 32'h5A5A_0000;
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return fresh_value(addr);
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int delay_from(input logic [31:0] s);
        return 1 + int'((s >> 16) & 32'd7);
    endfunction

    function automatic row_t make_row(input cache_pkg::cpu_op_t op, input logic [31:0] addr,
                                      input logic [31:0] wdata, input logic [31:0] rdata_exp,
                                      input int rd_exp, input int wr_exp);
        row_t r;
        r.op        = op;
        r.addr      = addr;
        r.wdata     = wdata;
        r.exp_rdata = rdata_exp;
        r.exp_rd    = rd_exp;
        r.exp_wr    = wr_exp;
        return r;
    endfunction

    // Expected traffic follows the LRU order traced from a freshly swept cache
    task automatic load_table();
        rows[0]  = make_row(RD, S5_T1, '0, fresh_value(S5_T1), 1, 0);
        rows[1]  = make_row(RD, S5_T1, '0, fresh_value(S5_T1), 0, 0);
        rows[2]  = make_row(WR, S5_T1, 32'hDEAD_BEEF, 32'hDEAD_BEEF, 0, 0);
        rows[3]  = make_row(RD, S5_T1, '0, 32'hDEAD_BEEF, 0, 0);
        rows[4]  = make_row(RD, S5_T2, '0, fresh_value(S5_T2), 1, 0);
        rows[5]  = make_row(RD, S5_T3, '0, fresh_value(S5_T3), 1, 1);
        rows[6]  = make_row(RD, S5_T1, '0, 32'hDEAD_BEEF, 1, 0);
        rows[7]  = make_row(RD, S5_T3, '0, fresh_value(S5_T3), 0, 0);
        rows[8]  = make_row(RD, S5_T2, '0, fresh_value(S5_T2), 1, 0);
        rows[9]  = make_row(WR, S5_T2, 32'h1234_5678, 32'h1234_5678, 0, 0);
        rows[10] = make_row(RD, S5_T4, '0, fresh_value(S5_T4), 1, 0);
        rows[11] = make_row(RD, S5_T1, '0, 32'hDEAD_BEEF, 1, 1);
        rows[12] = make_row(RD, S5_T2, '0, 32'h1234_5678, 1, 0);
        rows[13] = make_row(RD, S511_T7, '0, fresh_value(S511_T7), 1, 0);
        rows[14] = make_row(WR, S0_T0, 32'hCAFE_F00D, 32'hCAFE_F00D, 1, 0);
        rows[15] = make_row(RD, S0_T0, '0, 32'hCAFE_F00D, 0, 0);
        rows[16] = make_row(RD, S0_TMAX, '0, fresh_value(S0_TMAX), 1, 0);
        rows[17] = make_row(RD, S0_T0, '0, 32'hCAFE_F00D, 0, 0);
        rows[18] = make_row(RD, S1_T0, '0, fresh_value(S1_T0), 1, 0);
    endtask

    task automatic wait_ready(output logic ok);
        int n;
        n = 0;
        while (busy !== 1'b0 && n < READY_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        ok = (busy === 1'b0);
        if (!ok) begin
            $display("Timeout: busy did not fall after the reset sweep");
        end
    endtask

    task automatic run_row(input int i, output logic ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (busy !== 1'b0 && n < RESP_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (busy !== 1'b0) begin
            $display("Timeout: row %0d could not be issued, the cache stayed busy", i);
        end else begin
            req       <= 1'b1;
            cpu_req   <= '{op: rows[i].op, addr: rows[i].addr, wdata: rows[i].wdata};
            row_idx   <= i;
            exp_rdata <= rows[i].exp_rdata;
            exp_rd    <= rows[i].exp_rd;
            exp_wr    <= rows[i].exp_wr;
            @(posedge clk);
            req <= 1'b0;
            n = 0;
            while (resp_valid !== 1'b1 && n < RESP_TIMEOUT) begin
                @(posedge clk);
                n++;
            end
            if (resp_valid === 1'b1) begin
                ok = 1'b1;
            end else begin
                $display("Timeout: row %0d got no response from the cache", i);
            end
        end
    endtask

    // Memory model answers each strobe after a pseudo random delay
    always @(posedge clk) begin
        mem_done <= 1'b0;
        if (mem_rd || mem_wr) begin
            lcg_state    <= lcg_next(lcg_state);
            mem_wait     <= delay_from(lcg_next(lcg_state));
            mem_is_rd    <= mem_rd;
            mem_req_addr <= mem_addr;
            mem_pending  <= 1'b1;
            if (mem_wr) begin
                mem[mem_addr] = mem_wdata;
            end
        end else if (mem_pending) begin
            if (mem_wait <= 1) begin
                mem_pending <= 1'b0;
                mem_done    <= 1'b1;
                mem_rdata   <= mem_is_rd ? read_word(mem_req_addr) : '0;
            end else begin
                mem_wait <= mem_wait - 1;
            end
        end
    end

    initial begin
        forever #10 clk = ~clk;
    end

    initial begin
        load_table();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        wait_ready(run_ok);
        for (int i = 0; i < NUM_ROWS && run_ok; i++) begin
            run_row(i, run_ok);
        end
        @(posedge clk);
        $display("Summary: %0d checks passed, %0d failed, %0d assertion failures",
                 pass_cnt, fail_cnt, u_l1_cache_top.u_assert.err_total);
        if (run_ok && fail_cnt == 0 && pass_cnt == NUM_ROWS + 1 &&
            u_l1_cache_top.u_assert.err_total == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
